// ==== rtl/core_pkg.sv ====
package core_pkg;

    // ##################################################
    // widths
    // ##################################################

    typedef logic [63:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] instr_t;
    typedef logic [10:0] opcode_r_t;
    typedef logic [9:0]  opcode_i_t;

    // index 31 is the zero register.
    localparam reg_idx_t ZERO_REG = 5'd31;

    // ##################################################
    // opcodes
    // ##################################################

    // r-format, instr[31:21].
    localparam opcode_r_t OP_ADD  = 11'b10001011000;
    localparam opcode_r_t OP_SUB  = 11'b11001011000;
    localparam opcode_r_t OP_AND  = 11'b10001010000;
    localparam opcode_r_t OP_ORR  = 11'b10101010000;
    localparam opcode_r_t OP_EOR  = 11'b11001010000;
    localparam opcode_r_t OP_SUBS = 11'b11101011000;

    // i-format, instr[31:22].
    localparam opcode_i_t OP_ADDI = 10'b1001000100;
    localparam opcode_i_t OP_SUBI = 10'b1101000100;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_ORR = 3'd3,
        ALU_EOR = 3'd4
    } alu_op_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic     reg_write;
        logic     use_imm;
        logic     set_flags;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rn;
        reg_idx_t rm;
        word_t    imm;
    } ctrl_t;

endpackage

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic               clock,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t sel_a,
    input  core_pkg::reg_idx_t sel_b,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::word_t    wdata,
    input  logic               write,
    output core_pkg::word_t    rdata_a,
    output core_pkg::word_t    rdata_b
);

    // 31 real words, register 31 has no storage.
    core_pkg::word_t regs [0:30];
    logic [30:0]     load_en;

    // ##################################################
    // write decode
    // ##################################################

    always_comb begin
        for (int i = 0; i < 31; i++) begin
            load_en[i] = write && (waddr == core_pkg::reg_idx_t'(i));
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 31; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 31; i++) begin
                if (load_en[i]) begin
                    regs[i] <= wdata;
                end
            end
        end
    end

    // ##################################################
    // read ports
    // ##################################################

    // zero register reads as zero on both ports.
    always_comb begin
        if (sel_a == core_pkg::ZERO_REG) begin
            rdata_a = '0;
        end else begin
            rdata_a = regs[sel_a];
        end
        if (sel_b == core_pkg::ZERO_REG) begin
            rdata_b = '0;
        end else begin
            rdata_b = regs[sel_b];
        end
    end

endmodule

// ==== rtl/core_control.sv ====
`timescale 1ns/1ps

module core_control (
    input  core_pkg::instr_t instr,
    input  logic             instr_valid,
    output core_pkg::ctrl_t  ctrl,
    output logic             decode_ok
);

    core_pkg::opcode_r_t opc_r;
    core_pkg::opcode_i_t opc_i;
    logic                r_known;
    logic                i_known;
    logic                flag_op;
    core_pkg::alu_op_e   r_op;
    core_pkg::alu_op_e   i_op;

    assign opc_r = instr[31:21];
    assign opc_i = instr[31:22];

    // ##################################################
    // opcode match
    // ##################################################

    always_comb begin
        r_known = 1'b1;
        flag_op = 1'b0;
        r_op    = core_pkg::ALU_ADD;
        case (opc_r)
            core_pkg::OP_ADD:  r_op = core_pkg::ALU_ADD;
            core_pkg::OP_SUB:  r_op = core_pkg::ALU_SUB;
            core_pkg::OP_AND:  r_op = core_pkg::ALU_AND;
            core_pkg::OP_ORR:  r_op = core_pkg::ALU_ORR;
            core_pkg::OP_EOR:  r_op = core_pkg::ALU_EOR;
            core_pkg::OP_SUBS: begin
                r_op    = core_pkg::ALU_SUB;
                flag_op = 1'b1;
            end
            default: r_known = 1'b0;
        endcase
    end

    always_comb begin
        i_known = 1'b1;
        i_op    = core_pkg::ALU_ADD;
        case (opc_i)
            core_pkg::OP_ADDI: i_op = core_pkg::ALU_ADD;
            core_pkg::OP_SUBI: i_op = core_pkg::ALU_SUB;
            default:           i_known = 1'b0;
        endcase
    end

    // ##################################################
    // control word
    // ##################################################

    assign decode_ok = instr_valid && (r_known || i_known);

    always_comb begin
        ctrl.rd        = instr[4:0];
        ctrl.rn        = instr[9:5];
        ctrl.imm       = core_pkg::word_t'(instr[21:10]);
        ctrl.reg_write = decode_ok;
        ctrl.set_flags = instr_valid && r_known && flag_op;
        if (r_known) begin
            ctrl.use_imm = 1'b0;
            ctrl.alu_op  = r_op;
            ctrl.rm      = instr[20:16];
        end else begin
            // i-format, or unknown.
            ctrl.use_imm = i_known;
            ctrl.alu_op  = i_op;
            ctrl.rm      = core_pkg::ZERO_REG;
        end
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic             clock,
    input  logic             rst_n,
    input  core_pkg::ctrl_t  ctrl,
    input  core_pkg::word_t  op_a,
    input  core_pkg::word_t  op_b,
    output core_pkg::word_t  alu_out,
    output core_pkg::flags_t flags
);

    core_pkg::word_t  op_b_sel;
    core_pkg::word_t  b_eff;
    logic             is_sub;
    logic [64:0]      sum_ext;
    core_pkg::flags_t next_flags;

    // ##################################################
    // adder
    // ##################################################

    assign op_b_sel = ctrl.use_imm ? ctrl.imm : op_b;
    assign is_sub   = (ctrl.alu_op == core_pkg::ALU_SUB);

    // subtract as a + ~b + 1.
    assign b_eff   = is_sub ? ~op_b_sel : op_b_sel;
    assign sum_ext = {1'b0, op_a} + {1'b0, b_eff} + {64'b0, is_sub};

    always_comb begin
        case (ctrl.alu_op)
            core_pkg::ALU_ADD: alu_out = sum_ext[63:0];
            core_pkg::ALU_SUB: alu_out = sum_ext[63:0];
            core_pkg::ALU_AND: alu_out = op_a & op_b_sel;
            core_pkg::ALU_ORR: alu_out = op_a | op_b_sel;
            core_pkg::ALU_EOR: alu_out = op_a ^ op_b_sel;
            default:           alu_out = '0;
        endcase
    end

    // ##################################################
    // nzcv
    // ##################################################

    // carry out of the subtract means no borrow.
    always_comb begin
        next_flags.n = alu_out[63];
        next_flags.z = (alu_out == '0);
        next_flags.c = sum_ext[64];
        next_flags.v = (op_a[63] == b_eff[63]) && (sum_ext[63] != op_a[63]);
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ctrl.set_flags) begin
            flags <= next_flags;
        end
    end

endmodule

// ==== rtl/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
    input  logic            clock,
    input  logic            rst_n,
    input  core_pkg::word_t alu_out,
    input  logic            decode_ok,
    input  logic            instr_valid,
    output core_pkg::word_t result,
    output logic            result_valid,
    output logic            illegal
);

    logic bad_op;

    // strobe without a known opcode.
    assign bad_op = instr_valid && !decode_ok;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= decode_ok;
            illegal      <= bad_op;
        end
    end

    // result holds over illegal and idle cycles.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (decode_ok) begin
            result <= alu_out;
        end
    end

endmodule

// ==== rtl/exec_core.sv ====
`timescale 1ns/1ps

module exec_core (
    input  logic             clock,
    input  logic             rst_n,
    input  core_pkg::instr_t instr,
    input  logic             instr_valid,
    output core_pkg::word_t  result,
    output logic             result_valid,
    output logic             illegal,
    output core_pkg::flags_t flags
);

    core_pkg::ctrl_t ctrl;
    logic            decode_ok;
    core_pkg::word_t rdata_a;
    core_pkg::word_t rdata_b;
    core_pkg::word_t alu_out;

    // ##################################################
    // decode and operands
    // ##################################################

    core_control u_control (
        .instr       (instr),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .decode_ok   (decode_ok)
    );

    // write back lands on the same edge that samples the strobe.
    reg_file u_reg_file (
        .clock   (clock),
        .rst_n   (rst_n),
        .sel_a   (ctrl.rn),
        .sel_b   (ctrl.rm),
        .waddr   (ctrl.rd),
        .wdata   (alu_out),
        .write   (ctrl.reg_write),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    // ##################################################
    // execute and output
    // ##################################################

    alu u_alu (
        .clock   (clock),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .op_a    (rdata_a),
        .op_b    (rdata_b),
        .alu_out (alu_out),
        .flags   (flags)
    );

    result_stage u_result_stage (
        .clock        (clock),
        .rst_n        (rst_n),
        .alu_out      (alu_out),
        .decode_ok    (decode_ok),
        .instr_valid  (instr_valid),
        .result       (result),
        .result_valid (result_valid),
        .illegal      (illegal)
    );

endmodule

// ==== tests/exec_core_tb.sv ====
`timescale 1ns/1ps

module exec_core_tb;

    localparam int CLK_NS   = 20;
    localparam int N_MIX    = 100;
    localparam int N_ALU    = 200;
    localparam int N_ZERO   = 20;
    localparam int N_SUBS   = 60;
    localparam int N_ILL    = 40;
    localparam int N_CHAIN  = 100;
    localparam int TOTAL_INSTR = 32 + 62 + N_MIX + N_ALU + 3 * N_ZERO + N_SUBS + 80
                                 + 2 * N_ILL + N_CHAIN;
    // reset, idle cycles between tests, and slack.
    localparam int TOTAL_CYCLES = TOTAL_INSTR + 5 + 7 * 3 + 4;
    localparam int MARGIN       = 200;

    typedef struct packed {
        logic             valid;
        logic             bad;
        core_pkg::word_t  result;
        core_pkg::flags_t flags;
    } expect_t;

    logic               clock;
    logic               rst_n;
    core_pkg::instr_t   instr;
    logic               instr_valid;
    core_pkg::word_t    result;
    logic               result_valid;
    logic               illegal;
    core_pkg::flags_t   flags;

    core_pkg::word_t    ref_regs [0:31];
    core_pkg::flags_t   ref_flags;
    expect_t            exp_now;
    expect_t            exp_q;
    logic [31:0]        rng_state;
    core_pkg::instr_t   bad_instr;
    core_pkg::reg_idx_t chain_rd;
    core_pkg::reg_idx_t next_rd;
    core_pkg::reg_idx_t same_reg;
    string              test_name;
    int                 errors;
    int                 checks;
    int                 tests_run;
    int                 test_start_errors;

    exec_core u_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .instr        (instr),
        .instr_valid  (instr_valid),
        .result       (result),
        .result_valid (result_valid),
        .illegal      (illegal),
        .flags        (flags)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_NS / 2) clock = ~clock;
    end

    // expectation for the instruction driven one edge earlier.
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            exp_q <= '0;
        end else begin
            exp_q <= exp_now;
        end
    end

    // ##################################################
    // checks
    // ##################################################

    a_valid: assert property (@(posedge clock) disable iff (!rst_n)
        result_valid == exp_q.valid) checks++;
    else begin
        errors++;
        $display("Mismatch %s result_valid expected %0b actual %0b",
                 test_name, $sampled(exp_q.valid), $sampled(result_valid));
    end

    a_illegal: assert property (@(posedge clock) disable iff (!rst_n)
        illegal == exp_q.bad) checks++;
    else begin
        errors++;
        $display("Mismatch %s illegal expected %0b actual %0b",
                 test_name, $sampled(exp_q.bad), $sampled(illegal));
    end

    a_result: assert property (@(posedge clock) disable iff (!rst_n)
        result == exp_q.result) checks++;
    else begin
        errors++;
        $display("Mismatch %s result expected %h actual %h",
                 test_name, $sampled(exp_q.result), $sampled(result));
    end

    a_flags: assert property (@(posedge clock) disable iff (!rst_n)
        flags == exp_q.flags) checks++;
    else begin
        errors++;
        $display("Mismatch %s flags expected %b actual %b",
                 test_name, $sampled(exp_q.flags), $sampled(flags));
    end

    // ##################################################
    // stimulus helpers
    // ##################################################

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic core_pkg::reg_idx_t rand_any();
        return core_pkg::reg_idx_t'(next_rand());
    endfunction

    function automatic core_pkg::reg_idx_t rand_live();
        return core_pkg::reg_idx_t'(next_rand() % 31);
    endfunction

    function automatic core_pkg::instr_t encode_r(core_pkg::opcode_r_t op,
            core_pkg::reg_idx_t rm, core_pkg::reg_idx_t rn, core_pkg::reg_idx_t rd);
        return {op, rm, 6'b0, rn, rd};
    endfunction

    function automatic core_pkg::instr_t encode_i(core_pkg::opcode_i_t op,
            logic [11:0] imm, core_pkg::reg_idx_t rn, core_pkg::reg_idx_t rd);
        return {op, imm, rn, rd};
    endfunction

    function automatic logic is_known(core_pkg::instr_t ins);
        case (ins[31:21])
            core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND,
            core_pkg::OP_ORR, core_pkg::OP_EOR, core_pkg::OP_SUBS: return 1'b1;
            default: return (ins[31:22] == core_pkg::OP_ADDI) ||
                            (ins[31:22] == core_pkg::OP_SUBI);
        endcase
    endfunction

    function automatic core_pkg::instr_t random_illegal();
        core_pkg::instr_t ins;
        ins = next_rand();
        while (is_known(ins)) begin
            ins = next_rand();
        end
        return ins;
    endfunction

    function automatic core_pkg::instr_t random_alu(core_pkg::reg_idx_t rn,
            core_pkg::reg_idx_t rd);
        core_pkg::reg_idx_t rm;
        logic [11:0]        imm;
        rm  = rand_any();
        imm = 12'(next_rand());
        case (next_rand() % 7)
            0:       return encode_r(core_pkg::OP_ADD, rm, rn, rd);
            1:       return encode_r(core_pkg::OP_SUB, rm, rn, rd);
            2:       return encode_r(core_pkg::OP_AND, rm, rn, rd);
            3:       return encode_r(core_pkg::OP_ORR, rm, rn, rd);
            4:       return encode_r(core_pkg::OP_EOR, rm, rn, rd);
            5:       return encode_i(core_pkg::OP_ADDI, imm, rn, rd);
            default: return encode_i(core_pkg::OP_SUBI, imm, rn, rd);
        endcase
    endfunction

    function automatic core_pkg::word_t read_ref(core_pkg::reg_idx_t idx);
        return (idx == 5'd31) ? 64'd0 : ref_regs[idx];
    endfunction

    // reference model step, then drive for one cycle.
    task automatic issue(input core_pkg::instr_t ins);
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t imm;
        core_pkg::word_t res;
        logic            known;
        a     = read_ref(ins[9:5]);
        b     = read_ref(ins[20:16]);
        imm   = {52'b0, ins[21:10]};
        known = 1'b1;
        res   = '0;
        case (ins[31:21])
            core_pkg::OP_ADD: res = a + b;
            core_pkg::OP_SUB: res = a - b;
            core_pkg::OP_AND: res = a & b;
            core_pkg::OP_ORR: res = a | b;
            core_pkg::OP_EOR: res = a ^ b;
            core_pkg::OP_SUBS: begin
                res         = a - b;
                ref_flags.n = res[63];
                ref_flags.z = (res == 64'd0);
                ref_flags.c = (a >= b);
                ref_flags.v = (a[63] != b[63]) && (res[63] != a[63]);
            end
            default: begin
                if (ins[31:22] == core_pkg::OP_ADDI) begin
                    res = a + imm;
                end else if (ins[31:22] == core_pkg::OP_SUBI) begin
                    res = a - imm;
                end else begin
                    known = 1'b0;
                end
            end
        endcase
        if (known && ins[4:0] != 5'd31) begin
            ref_regs[ins[4:0]] = res;
        end
        exp_now.valid <= known;
        exp_now.bad   <= !known;
        exp_now.flags <= ref_flags;
        if (known) begin
            exp_now.result <= res;
        end
        instr       <= ins;
        instr_valid <= 1'b1;
        @(posedge clock);
    endtask

    // random instruction bits while the strobe is low.
    task automatic idle(input int cycles);
        repeat (cycles) begin
            exp_now.valid <= 1'b0;
            exp_now.bad   <= 1'b0;
            instr         <= next_rand();
            instr_valid   <= 1'b0;
            @(posedge clock);
        end
    endtask

    task automatic start_test(input string name);
        @(posedge clock);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        idle(2);
        // checks of the last edge settle before the count.
        @(negedge clock);
        tests_run++;
        $display("test %-8s %s, %0d errors", test_name,
                 (errors == test_start_errors) ? "ok" : "FAILED", errors - test_start_errors);
    endtask

    // ##################################################
    // tests
    // ##################################################

    initial begin
        rng_state   = 32'h79b73b6d;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        exp_now     = '0;
        ref_flags   = '0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        test_name   = "reset";
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;

        start_test("reset");
        for (int i = 0; i < 32; i++) begin
            issue(encode_r(core_pkg::OP_ORR, core_pkg::ZERO_REG, core_pkg::reg_idx_t'(i),
                           core_pkg::ZERO_REG));
        end
        finish_test();

        start_test("load");
        for (int i = 0; i < 31; i++) begin
            issue(encode_i(core_pkg::OP_ADDI, 12'(next_rand()), core_pkg::ZERO_REG,
                           core_pkg::reg_idx_t'(i)));
        end
        // wraps about half the registers to full-width values.
        for (int i = 0; i < 31; i++) begin
            issue(encode_i(core_pkg::OP_SUBI, 12'(next_rand()), core_pkg::reg_idx_t'(i),
                           core_pkg::reg_idx_t'(i)));
        end
        for (int i = 0; i < N_MIX; i++) begin
            issue(encode_r((next_rand() % 2 == 0) ? core_pkg::OP_ADD : core_pkg::OP_ORR,
                           rand_live(), rand_live(), rand_live()));
        end
        finish_test();

        start_test("alu");
        for (int i = 0; i < N_ALU; i++) begin
            issue(random_alu(rand_any(), rand_any()));
        end
        finish_test();

        start_test("zero");
        for (int i = 0; i < N_ZERO; i++) begin
            issue(random_alu(rand_live(), core_pkg::ZERO_REG));
            issue(encode_r(core_pkg::OP_ORR, core_pkg::ZERO_REG, core_pkg::ZERO_REG,
                           core_pkg::ZERO_REG));
            issue(encode_r(core_pkg::OP_ADD, rand_live(), core_pkg::ZERO_REG,
                           core_pkg::ZERO_REG));
        end
        finish_test();

        start_test("flags");
        for (int i = 0; i < N_SUBS; i++) begin
            issue(encode_r(core_pkg::OP_SUBS, rand_any(), rand_any(), rand_live()));
        end
        same_reg = rand_live();
        issue(encode_r(core_pkg::OP_SUBS, same_reg, same_reg, core_pkg::ZERO_REG));
        // x1 = 1, x2 = 2^63 by doubling.
        issue(encode_i(core_pkg::OP_ADDI, 12'd1, core_pkg::ZERO_REG, 5'd1));
        issue(encode_i(core_pkg::OP_ADDI, 12'd1, core_pkg::ZERO_REG, 5'd2));
        repeat (63) issue(encode_r(core_pkg::OP_ADD, 5'd2, 5'd2, 5'd2));
        issue(encode_r(core_pkg::OP_SUBS, 5'd1, 5'd2, 5'd3));
        issue(encode_i(core_pkg::OP_SUBI, 12'd1, core_pkg::ZERO_REG, 5'd4));
        issue(encode_r(core_pkg::OP_SUBS, 5'd4, 5'd3, 5'd5));
        issue(encode_r(core_pkg::OP_ADD, 5'd1, 5'd1, 5'd6));
        issue(encode_r(core_pkg::OP_SUBS, 5'd4, 5'd1, 5'd7));
        finish_test();

        start_test("illegal");
        for (int i = 0; i < N_ILL; i++) begin
            bad_instr = random_illegal();
            issue(bad_instr);
            issue(encode_r(core_pkg::OP_ORR, core_pkg::ZERO_REG, bad_instr[4:0],
                           core_pkg::ZERO_REG));
        end
        finish_test();

        start_test("chain");
        chain_rd = rand_live();
        for (int i = 0; i < N_CHAIN; i++) begin
            next_rd = rand_live();
            issue(random_alu(chain_rd, next_rd));
            chain_rd = next_rd;
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(CLK_NS * (TOTAL_CYCLES + MARGIN));
        $display("watchdog timeout, run did not finish in %0d cycles", TOTAL_CYCLES + MARGIN);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/core_control.sv
rtl/alu.sv
rtl/result_stage.sv
rtl/exec_core.sv
tests/exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

dependencies: {}

sources:
  # package first, then leaf modules, then the top level.
  - files:
      - rtl/core_pkg.sv
      - rtl/reg_file.sv
      - rtl/core_control.sv
      - rtl/alu.sv
      - rtl/result_stage.sv
      - rtl/exec_core.sv

  - target: test
    files:
      - tests/exec_core_tb.sv
